/* project.f */
+incdir+include
hdl/soc_pkg.sv
hdl/wb_region_decoder.sv
hdl/wb_ram_slave.sv
hdl/wb_clint_slave.sv
hdl/wb_uart_tx_slave.sv
hdl/wb_soc_fabric.sv
bench/tb_wb_soc.sv

/* run.sh */
#!/bin/sh
# Build and run the Wishbone fabric testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_wb_soc -f project.f

# Pass only if the testbench reports it
if ./obj_dir/Vtb_wb_soc | tee /dev/stderr | grep "TB PASSED" > /dev/null; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

/* include/tb_wb_tasks.svh */
/* Master and serial helpers, included inside tb_wb_soc and driving its bus signals.
   Requests start on a falling edge; every response wait is bounded by TIMEOUT_CYCLES. */
`ifndef TB_WB_TASKS_SVH
`define TB_WB_TASKS_SVH

// ============================================================
// Wishbone master
// ============================================================

// Fixed bit-timing delay, counted in falling edges
task automatic wait_negedges(input int n);
  for (int i = 0; i < n; i++) begin
    @(negedge clk);
  end
endtask

// One beat; the request stays up afterwards when hold is set
task automatic bus_transfer(input logic we, input addr_t adr, input data_t dat,
                            input sel_t sel, input cti_e cti, input logic hold,
                            output data_t rdat, output int cycles, output logic got_err);
  @(negedge clk);
  wb_cyc  = 1'b1;
  wb_stb  = 1'b1;
  wb_we   = we;
  wb_adr  = adr;
  wb_wdat = dat;
  wb_sel  = sel;
  wb_cti  = cti;
  cycles  = 0;
  // Response counted in cycles after the request
  do begin
    @(negedge clk);
    cycles++;
    if (cycles > TIMEOUT_CYCLES) begin
      fail_now($sformatf("no ack or err for the access to 0x%08h", adr));
    end
  end while (!wb_ack && !wb_err);
  rdat    = wb_rdat;
  got_err = wb_err;
  if (!hold) begin
    // Completion edge has passed, release the bus
    @(negedge clk);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    wb_cti = CTI_CLASSIC;
  end
endtask

task automatic bus_write(input addr_t adr, input data_t dat, input sel_t sel,
                         output int cycles);
  data_t rdat;
  logic  got_err;
  bus_transfer(1'b1, adr, dat, sel, CTI_CLASSIC, 1'b0, rdat, cycles, got_err);
  if (got_err) begin
    fail_now($sformatf("bus error on the write to 0x%08h", adr));
  end
endtask

task automatic bus_read(input addr_t adr, output data_t rdat, output int cycles);
  logic got_err;
  bus_transfer(1'b0, adr, '0, 4'hF, CTI_CLASSIC, 1'b0, rdat, cycles, got_err);
  if (got_err) begin
    fail_now($sformatf("bus error on the read from 0x%08h", adr));
  end
endtask

// Incrementing burst over one line, results land in burst_words and burst_cycles
task automatic bus_burst_read(input addr_t base);
  cti_e cti;
  logic last;
  logic got_err;
  for (int i = 0; i < LINE_WORDS; i++) begin
    last = (i == LINE_WORDS - 1);
    cti  = last ? CTI_EOB : CTI_INCR;
    bus_transfer(1'b0, base + addr_t'(4 * i), '0, 4'hF, cti, !last,
                 burst_words[i], burst_cycles[i], got_err);
    if (got_err) begin
      fail_now($sformatf("bus error on burst beat %0d", i));
    end
  end
endtask

// ============================================================
// Serial frame sampler
// ============================================================

// Samples each bit near its middle, starting from the falling start edge
task automatic uart_frame_sample(output logic [7:0] rx, output logic stop_ok,
                                 output int stop_cycle);
  int waited;
  waited = 0;
  while (uart_tx) begin
    @(negedge clk);
    waited++;
    if (waited > TIMEOUT_CYCLES) begin
      fail_now("no start bit on uart0_tx_o");
    end
  end
  wait_negedges(CLKS_PER_BIT / 2);
  if (uart_tx) begin
    fail_now("start bit on uart0_tx_o ended before its middle");
  end
  // LSB first
  for (int b = 0; b < 8; b++) begin
    wait_negedges(CLKS_PER_BIT);
    rx[b] = uart_tx;
  end
  wait_negedges(CLKS_PER_BIT);
  stop_ok    = uart_tx;
  stop_cycle = cycle_cnt;
endtask

`endif

/* bench/tb_wb_soc.sv */
/* Self-checking testbench for wb_soc_fabric with default parameters.
   Stops at the first failed check; random stimulus uses a fixed seed. */
`timescale 1ns/1ns

module tb_wb_soc
  import soc_pkg::*;
();

  // Mirrors of the DUT defaults
  localparam int RAM_WORDS      = 1024;
  localparam int RAM_LATENCY    = 4;
  localparam int CLKS_PER_BIT   = 8;
  localparam int TIMEOUT_CYCLES = 200;
  localparam int TEST_WORDS     = 8;

  logic  clk;
  logic  rst_n;
  logic  wb_cyc;
  logic  wb_stb;
  logic  wb_we;
  addr_t wb_adr;
  data_t wb_wdat;
  sel_t  wb_sel;
  cti_e  wb_cti;
  data_t wb_rdat;
  logic  wb_ack;
  logic  wb_err;
  logic  timer_irq;
  logic  sw_irq;
  logic  uart_tx;

  int         cycle_cnt = 0;
  // Byte-wise RAM reference
  logic [7:0] model_bytes [4*RAM_WORDS];
  data_t      burst_words [LINE_WORDS];
  int         burst_cycles [LINE_WORDS];

  wb_soc_fabric i_dut (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .wb_cyc_i    (wb_cyc),
    .wb_stb_i    (wb_stb),
    .wb_we_i     (wb_we),
    .wb_adr_i    (wb_adr),
    .wb_dat_i    (wb_wdat),
    .wb_sel_i    (wb_sel),
    .wb_cti_i    (wb_cti),
    .wb_dat_o    (wb_rdat),
    .wb_ack_o    (wb_ack),
    .wb_err_o    (wb_err),
    .timer_irq_o (timer_irq),
    .sw_irq_o    (sw_irq),
    .uart0_tx_o  (uart_tx)
  );

  // 100 ns period
  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // ============================================================
  // Checks and reference model
  // ============================================================
  task automatic fail_now(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_value(input string name, input data_t got, input data_t exp);
    assert (got === exp)
      else fail_now($sformatf("mismatch %s: got 0x%08h expected 0x%08h", name, got, exp));
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    assert (got == exp)
      else fail_now($sformatf("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  function automatic addr_t ram_addr(input int idx);
    return RAM_BASE | (addr_t'(idx) << 2);
  endfunction

  function automatic addr_t clint_addr(input logic [15:0] ofs);
    return CLINT_BASE | {16'h0, ofs};
  endfunction

  function automatic addr_t uart_addr(input logic [15:0] ofs);
    return PBUS_BASE | {12'h0, UART0_SLOT, ofs};
  endfunction

  task automatic model_write(input int idx, input data_t dat, input sel_t sel);
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) begin
        model_bytes[4*idx + b] = dat[8*b +: 8];
      end
    end
  endtask

  function automatic data_t model_word(input int idx);
    return {model_bytes[4*idx + 3], model_bytes[4*idx + 2],
            model_bytes[4*idx + 1], model_bytes[4*idx]};
  endfunction

  `include "tb_wb_tasks.svh"

  // Responses are single-cycle pulses and never overlap
  a_ack_pulse : assert property (@(posedge clk) disable iff (!rst_n)
    !(wb_ack && $past(wb_ack)))
    else fail_now("wb_ack_o stayed high for two cycles");

  a_err_pulse : assert property (@(posedge clk) disable iff (!rst_n)
    !(wb_err && $past(wb_err)))
    else fail_now("wb_err_o stayed high for two cycles");

  a_ack_xor_err : assert property (@(posedge clk) disable iff (!rst_n)
    !(wb_ack && wb_err))
    else fail_now("wb_ack_o and wb_err_o high in the same cycle");

  // ============================================================
  // Stimulus
  // ============================================================
  initial begin
    data_t      rdat;
    data_t      wdat;
    data_t      mtime_a;
    data_t      mtime_b;
    sel_t       sel;
    int         cyc;
    int         waited;
    int         line;
    int         idx [TEST_WORDS];
    logic       got_err;
    logic [7:0] tx_a;
    logic [7:0] tx_b;
    logic [7:0] rx_byte;
    logic       stop_ok;
    int         stop_cycle;
    int         ack_cycle;
    addr_t      bad_adr;

    void'($urandom(59));
    clk     = 1'b0;
    rst_n   = 1'b0;
    wb_cyc  = 1'b0;
    wb_stb  = 1'b0;
    wb_we   = 1'b0;
    wb_adr  = '0;
    wb_wdat = '0;
    wb_sel  = '0;
    wb_cti  = CTI_CLASSIC;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;

    check_value("wb_ack_o after reset", data_t'(wb_ack), 32'h0);
    check_value("wb_err_o after reset", data_t'(wb_err), 32'h0);
    check_value("timer_irq_o after reset", data_t'(timer_irq), 32'h0);
    check_value("sw_irq_o after reset", data_t'(sw_irq), 32'h0);
    check_value("uart0_tx_o after reset", data_t'(uart_tx), 32'h1);

    // RAM words written whole first so no byte stays unknown
    for (int k = 0; k < TEST_WORDS; k++) begin
      idx[k] = $urandom % RAM_WORDS;
      wdat   = $urandom;
      bus_write(ram_addr(idx[k]), wdat, 4'hF, cyc);
      model_write(idx[k], wdat, 4'hF);
      check_count("wb_ack_o RAM write latency", cyc, 1);
    end
    // Partial writes on the same words
    for (int k = 0; k < 3 * TEST_WORDS; k++) begin
      line = idx[$urandom % TEST_WORDS];
      wdat = $urandom;
      sel  = sel_t'($urandom);
      bus_write(ram_addr(line), wdat, sel, cyc);
      model_write(line, wdat, sel);
    end
    for (int k = 0; k < TEST_WORDS; k++) begin
      bus_read(ram_addr(idx[k]), rdat, cyc);
      check_value("wb_dat_o RAM read", rdat, model_word(idx[k]));
      check_count("wb_ack_o RAM read latency", cyc, RAM_LATENCY);
    end

    // Burst over one aligned line
    line = ($urandom % (RAM_WORDS / LINE_WORDS)) * LINE_WORDS;
    for (int k = 0; k < LINE_WORDS; k++) begin
      wdat = $urandom;
      bus_write(ram_addr(line + k), wdat, 4'hF, cyc);
      model_write(line + k, wdat, 4'hF);
    end
    bus_burst_read(ram_addr(line));
    for (int k = 0; k < LINE_WORDS; k++) begin
      check_value("wb_dat_o burst beat", burst_words[k], model_word(line + k));
      check_count("wb_ack_o burst beat latency", burst_cycles[k],
                  (k == 0) ? RAM_LATENCY : 1);
    end

    // ============================================================
    // CLINT
    // ============================================================
    bus_write(clint_addr(CLINT_MSIP_OFS), 32'h1, 4'h1, cyc);
    check_count("wb_ack_o CLINT write latency", cyc, 1);
    check_value("sw_irq_o after msip set", data_t'(sw_irq), 32'h1);
    bus_write(clint_addr(CLINT_MSIP_OFS), 32'h0, 4'h1, cyc);
    check_value("sw_irq_o after msip clear", data_t'(sw_irq), 32'h0);

    bus_read(clint_addr(CLINT_MTIME_OFS), mtime_a, cyc);
    check_count("wb_ack_o CLINT read latency", cyc, 1);
    bus_read(clint_addr(CLINT_MTIME_OFS), mtime_b, cyc);
    if (mtime_b <= mtime_a) begin
      fail_now($sformatf("mtime did not advance: 0x%08h then 0x%08h", mtime_a, mtime_b));
    end

    bus_write(clint_addr(CLINT_MTIMECMP_OFS), mtime_b + 32'd20, 4'hF, cyc);
    check_value("timer_irq_o before the compare", data_t'(timer_irq), 32'h0);
    bus_read(clint_addr(CLINT_MTIMECMP_OFS), rdat, cyc);
    check_value("wb_dat_o mtimecmp", rdat, mtime_b + 32'd20);
    waited = 0;
    while (!timer_irq) begin
      @(negedge clk);
      waited++;
      if (waited > TIMEOUT_CYCLES) begin
        fail_now("timer_irq_o did not rise after the mtimecmp write");
      end
    end
    // Level stays while mtime is past the compare
    for (int k = 0; k < 16; k++) begin
      @(negedge clk);
      check_value("timer_irq_o held", data_t'(timer_irq), 32'h1);
    end

    // ============================================================
    // UART
    // ============================================================
    bus_read(uart_addr(UART_STATUS_OFS), rdat, cyc);
    check_value("wb_dat_o uart status idle", rdat, 32'h0);
    tx_a = 8'($urandom);
    tx_b = 8'($urandom);
    bus_write(uart_addr(UART_DATA_OFS), {24'h0, tx_a}, 4'h1, cyc);
    check_count("wb_ack_o UART idle write latency", cyc, 1);
    // Second write waits behind the running frame
    fork
      uart_frame_sample(rx_byte, stop_ok, stop_cycle);
      begin
        bus_write(uart_addr(UART_DATA_OFS), {24'h0, tx_b}, 4'h1, cyc);
        ack_cycle = cycle_cnt - 1;
      end
    join
    check_value("uart0_tx_o first byte", data_t'(rx_byte), data_t'(tx_a));
    check_value("uart0_tx_o first stop bit", data_t'(stop_ok), 32'h1);
    if (ack_cycle <= stop_cycle) begin
      fail_now("second UART write was acked before the first stop bit");
    end
    fork
      uart_frame_sample(rx_byte, stop_ok, stop_cycle);
      begin
        bus_read(uart_addr(UART_STATUS_OFS), rdat, cyc);
        check_value("wb_dat_o uart status busy", rdat, 32'h1);
        check_count("wb_ack_o UART status latency", cyc, 1);
      end
    join
    check_value("uart0_tx_o second byte", data_t'(rx_byte), data_t'(tx_b));
    check_value("uart0_tx_o second stop bit", data_t'(stop_ok), 32'h1);

    // ============================================================
    // Unmapped addresses
    // ============================================================
    bad_adr = {4'h5, 28'($urandom)} & ~32'h3;
    bus_transfer(1'b0, bad_adr, '0, 4'hF, CTI_CLASSIC, 1'b0, rdat, cyc, got_err);
    check_value("wb_err_o unmapped read", data_t'(got_err), 32'h1);
    check_count("wb_err_o unmapped latency", cyc, 1);
    // Empty peripheral slot
    bad_adr = PBUS_BASE | {12'h0, 4'(1 + ($urandom % 15)), 16'h0};
    bus_transfer(1'b1, bad_adr, $urandom, 4'hF, CTI_CLASSIC, 1'b0, rdat, cyc, got_err);
    check_value("wb_err_o empty slot write", data_t'(got_err), 32'h1);
    check_count("wb_err_o empty slot latency", cyc, 1);

    $display("TB PASSED");
    $finish;
  end

endmodule

/* hdl/wb_soc_fabric.sv */
/* Wishbone B4 classic fabric with RAM, CLINT and UART0; one transfer in flight, no stall.
   The external master must hold its request until ack or err. */
`timescale 1ns/1ns

module wb_soc_fabric
  import soc_pkg::*;
#(
  parameter int RAM_WORDS    = 1024,
  parameter int RAM_LATENCY  = 4,
  parameter int CLKS_PER_BIT = 8
) (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  wb_cyc_i,
  input  logic  wb_stb_i,
  input  logic  wb_we_i,
  input  addr_t wb_adr_i,
  input  data_t wb_dat_i,
  input  sel_t  wb_sel_i,
  input  cti_e  wb_cti_i,
  output data_t wb_dat_o,
  output logic  wb_ack_o,
  output logic  wb_err_o,
  output logic  timer_irq_o,
  output logic  sw_irq_o,
  output logic  uart0_tx_o
);

  // Per-slave strobes and responses
  logic  ram_stb;
  logic  clint_stb;
  logic  uart_stb;
  data_t ram_dat;
  data_t clint_dat;
  data_t uart_dat;
  logic  ram_ack;
  logic  clint_ack;
  logic  uart_ack;

  // ============================================================
  // Decoder
  // ============================================================
  wb_region_decoder i_decoder (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .wb_cyc_i    (wb_cyc_i),
    .wb_stb_i    (wb_stb_i),
    .wb_adr_i    (wb_adr_i),
    .ram_dat_i   (ram_dat),
    .ram_ack_i   (ram_ack),
    .clint_dat_i (clint_dat),
    .clint_ack_i (clint_ack),
    .uart_dat_i  (uart_dat),
    .uart_ack_i  (uart_ack),
    .ram_stb_o   (ram_stb),
    .clint_stb_o (clint_stb),
    .uart_stb_o  (uart_stb),
    .wb_dat_o    (wb_dat_o),
    .wb_ack_o    (wb_ack_o),
    .wb_err_o    (wb_err_o)
  );

  // ============================================================
  // Slaves
  // ============================================================
  wb_ram_slave #(
    .RAM_WORDS   (RAM_WORDS),
    .RAM_LATENCY (RAM_LATENCY)
  ) i_ram (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .stb_i  (ram_stb),
    .we_i   (wb_we_i),
    .adr_i  (wb_adr_i),
    .dat_i  (wb_dat_i),
    .sel_i  (wb_sel_i),
    .cti_i  (wb_cti_i),
    .dat_o  (ram_dat),
    .ack_o  (ram_ack)
  );

  wb_clint_slave i_clint (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .stb_i       (clint_stb),
    .we_i        (wb_we_i),
    .adr_i       (wb_adr_i),
    .dat_i       (wb_dat_i),
    .sel_i       (wb_sel_i),
    .dat_o       (clint_dat),
    .ack_o       (clint_ack),
    .timer_irq_o (timer_irq_o),
    .sw_irq_o    (sw_irq_o)
  );

  wb_uart_tx_slave #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) i_uart0 (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .stb_i      (uart_stb),
    .we_i       (wb_we_i),
    .adr_i      (wb_adr_i),
    .dat_i      (wb_dat_i),
    .dat_o      (uart_dat),
    .ack_o      (uart_ack),
    .uart0_tx_o (uart0_tx_o)
  );

endmodule

/* hdl/wb_uart_tx_slave.sv */
/* Transmit-only 8N1 UART; a data write while busy is stalled until the frame ends.
   Status bit 0 is busy; there is no FIFO and no receiver. */
`timescale 1ns/1ns

module wb_uart_tx_slave
  import soc_pkg::*;
#(
  parameter int CLKS_PER_BIT = 8
) (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  stb_i,
  input  logic  we_i,
  input  addr_t adr_i,
  input  data_t dat_i,
  output data_t dat_o,
  output logic  ack_o,
  output logic  uart0_tx_o
);

  localparam int CW = $clog2(CLKS_PER_BIT + 1);

  typedef enum logic [1:0] {
    IDLE,
    START,
    DATA,
    STOP
  } tx_state_e;

  tx_state_e      state_q;
  logic [CW-1:0]  cnt_q;
  logic [2:0]     bit_q;
  logic [7:0]     shift_q;
  logic           tx_q;
  logic           ack_q;
  data_t          dat_q;

  logic data_wr;
  logic accept;
  logic take;
  logic bit_end;

  assign data_wr = we_i && (adr_i[15:0] == UART_DATA_OFS);
  // Frame load only from IDLE
  assign accept  = stb_i && !ack_q && data_wr && (state_q == IDLE);
  // Everything else is acked right away
  assign take    = accept || (stb_i && !ack_q && !data_wr);
  assign bit_end = (cnt_q == CW'(CLKS_PER_BIT - 1));

  // ============================================================
  // Frame FSM
  // ============================================================
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      cnt_q   <= '0;
      bit_q   <= '0;
      tx_q    <= 1'b1;
      ack_q   <= 1'b0;
    end else begin
      ack_q <= take;
      case (state_q)
        IDLE: begin
          tx_q <= 1'b1;
          if (accept) begin
            state_q <= START;
            cnt_q   <= '0;
            tx_q    <= 1'b0;
          end
        end
        START: begin
          if (bit_end) begin
            cnt_q   <= '0;
            bit_q   <= '0;
            state_q <= DATA;
            tx_q    <= shift_q[0];
          end else begin
            cnt_q <= cnt_q + CW'(1);
          end
        end
        DATA: begin
          if (bit_end) begin
            cnt_q <= '0;
            if (bit_q == 3'd7) begin
              state_q <= STOP;
              tx_q    <= 1'b1;
            end else begin
              bit_q <= bit_q + 3'd1;
              tx_q  <= shift_q[bit_q + 3'd1];
            end
          end else begin
            cnt_q <= cnt_q + CW'(1);
          end
        end
        STOP: begin
          // Line already high
          if (bit_end) begin
            cnt_q   <= '0;
            state_q <= IDLE;
          end else begin
            cnt_q <= cnt_q + CW'(1);
          end
        end
        default: begin
          state_q <= IDLE;
          tx_q    <= 1'b1;
        end
      endcase
    end
  end

  // Byte held for the whole frame
  always_ff @(posedge clk_i) begin
    if (accept) begin
      shift_q <= dat_i[7:0];
    end
  end

  // Status read data
  always_ff @(posedge clk_i) begin
    if (take) begin
      if (!we_i && (adr_i[15:0] == UART_STATUS_OFS)) begin
        dat_q <= {31'b0, state_q != IDLE};
      end else begin
        dat_q <= '0;
      end
    end
  end

  assign dat_o      = dat_q;
  assign ack_o      = ack_q;
  assign uart0_tx_o = tx_q;

  // Idle line is a mark
  a_idle_high : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q == IDLE) |-> uart0_tx_o);

endmodule

/* hdl/wb_clint_slave.sv */
/* CLINT with a 32-bit free-running mtime; mtime is read-only.
   Unknown offsets read zero and ignore writes. */
`timescale 1ns/1ns

module wb_clint_slave
  import soc_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  stb_i,
  input  logic  we_i,
  input  addr_t adr_i,
  input  data_t dat_i,
  input  sel_t  sel_i,
  output data_t dat_o,
  output logic  ack_o,
  output logic  timer_irq_o,
  output logic  sw_irq_o
);

  data_t mtime_q;
  data_t mtimecmp_q;
  logic  msip_q;
  logic  timer_irq_q;
  logic  ack_q;
  data_t dat_q;
  logic  acc;

  // Single-cycle access
  assign acc = stb_i && !ack_q;

  // ============================================================
  // Timer and registers
  // ============================================================
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      mtime_q     <= '0;
      mtimecmp_q  <= '1;
      msip_q      <= 1'b0;
      timer_irq_q <= 1'b0;
      ack_q       <= 1'b0;
    end else begin
      mtime_q     <= mtime_q + 32'd1;
      timer_irq_q <= (mtime_q >= mtimecmp_q);
      ack_q       <= acc;

      if (acc && we_i) begin
        case (adr_i[15:0])
          CLINT_MSIP_OFS: begin
            if (sel_i[0]) begin
              msip_q <= dat_i[0];
            end
          end
          CLINT_MTIMECMP_OFS: begin
            // Byte lanes
            for (int b = 0; b < 4; b++) begin
              if (sel_i[b]) begin
                mtimecmp_q[8*b +: 8] <= dat_i[8*b +: 8];
              end
            end
          end
          default: begin
            // mtime and holes ignore writes
          end
        endcase
      end
    end
  end

  // Read data, registered with ack
  always_ff @(posedge clk_i) begin
    if (acc) begin
      case (adr_i[15:0])
        CLINT_MSIP_OFS:     dat_q <= {31'b0, msip_q};
        CLINT_MTIMECMP_OFS: dat_q <= mtimecmp_q;
        CLINT_MTIME_OFS:    dat_q <= mtime_q;
        default:            dat_q <= '0;
      endcase
    end
  end

  assign dat_o       = dat_q;
  assign ack_o       = ack_q;
  assign timer_irq_o = timer_irq_q;
  assign sw_irq_o    = msip_q;

endmodule

/* hdl/wb_ram_slave.sv */
/* Word RAM; first read beat waits RAM_LATENCY cycles, later INCR beats come from a line buffer.
   Needs RAM_LATENCY >= 2 and RAM_WORDS a power of two of at least LINE_WORDS. */
`timescale 1ns/1ns

module wb_ram_slave
  import soc_pkg::*;
#(
  parameter int RAM_WORDS   = 1024,
  parameter int RAM_LATENCY = 4
) (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  stb_i,
  input  logic  we_i,
  input  addr_t adr_i,
  input  data_t dat_i,
  input  sel_t  sel_i,
  input  cti_e  cti_i,
  output data_t dat_o,
  output logic  ack_o
);

  localparam int AW       = $clog2(RAM_WORDS);
  localparam int LW_BITS  = $clog2(LINE_WORDS);
  localparam int LINE_LSB = 2 + LW_BITS;

  data_t mem [RAM_WORDS];

  // Line buffer and its tag
  data_t                line_q [LINE_WORDS];
  logic [31:LINE_LSB]   line_tag_q;
  logic                 buf_valid_q;

  logic [RAM_LATENCY-2:0] chain_q;
  logic                   ack_q;
  data_t                  dat_q;

  logic [AW-1:0] widx;
  logic          wr_go;
  logic          rd_start;
  logic          capture;
  logic          buf_hit;

  assign widx = adr_i[2 +: AW];

  // Write takes one cycle
  assign wr_go    = stb_i && we_i && !ack_q;
  // Fresh read only with an empty buffer and nothing pending
  assign rd_start = stb_i && !we_i && !buf_valid_q && !(|chain_q) && !ack_q;
  // End of the latency chain
  assign capture  = chain_q[RAM_LATENCY-2];
  // Burst beat served from the line
  assign buf_hit  = stb_i && !we_i && buf_valid_q && !ack_q;

  // ============================================================
  // Storage
  // ============================================================
  always_ff @(posedge clk_i) begin
    if (wr_go) begin
      for (int b = 0; b < 4; b++) begin
        if (sel_i[b]) begin
          mem[widx][8*b +: 8] <= dat_i[8*b +: 8];
        end
      end
    end
    if (capture) begin
      // Whole aligned line around the addressed word
      for (int i = 0; i < LINE_WORDS; i++) begin
        line_q[i] <= mem[{widx[AW-1:LW_BITS], LW_BITS'(i)}];
      end
      line_tag_q <= adr_i[31:LINE_LSB];
    end
  end

  // Read data register
  always_ff @(posedge clk_i) begin
    if (capture) begin
      dat_q <= mem[widx];
    end else if (buf_hit) begin
      dat_q <= line_q[adr_i[LINE_LSB-1:2]];
    end
  end

  // ============================================================
  // Handshake and burst control
  // ============================================================
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      ack_q       <= 1'b0;
      chain_q     <= '0;
      buf_valid_q <= 1'b0;
    end else begin
      ack_q   <= 1'b0;
      // Chain is dropped if the master abandons the cycle
      chain_q <= stb_i ? ((chain_q << 1) | (RAM_LATENCY-1)'(rd_start)) : '0;

      if (wr_go) begin
        ack_q <= 1'b1;
      end else if (capture) begin
        ack_q       <= 1'b1;
        buf_valid_q <= (cti_i == CTI_INCR);
      end else if (buf_hit) begin
        ack_q <= 1'b1;
      end

      // Buffer dies at EOB completion, stb drop or any write
      if (!stb_i || we_i) begin
        buf_valid_q <= 1'b0;
      end else if (ack_q && (cti_i == CTI_EOB)) begin
        buf_valid_q <= 1'b0;
      end
    end
  end

  assign ack_o = ack_q;
  assign dat_o = dat_q;

  // Burst must not walk out of the buffered line
  a_burst_in_line : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (stb_i && !we_i && buf_valid_q) |-> (adr_i[31:LINE_LSB] == line_tag_q));

endmodule

/* hdl/wb_region_decoder.sv */
/* Combinational region decode; only one transfer is in flight at a time.
   Unmapped addresses and unused peripheral slots answer with a one-cycle err. */
`timescale 1ns/1ns

module wb_region_decoder
  import soc_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_ni,
  input  logic    wb_cyc_i,
  input  logic    wb_stb_i,
  input  addr_t   wb_adr_i,
  input  data_t   ram_dat_i,
  input  logic    ram_ack_i,
  input  data_t   clint_dat_i,
  input  logic    clint_ack_i,
  input  data_t   uart_dat_i,
  input  logic    uart_ack_i,
  output logic    ram_stb_o,
  output logic    clint_stb_o,
  output logic    uart_stb_o,
  output data_t   wb_dat_o,
  output logic    wb_ack_o,
  output logic    wb_err_o
);

  region_e region;
  logic    req;
  logic    err_q;

  assign req = wb_cyc_i && wb_stb_i;

  // ============================================================
  // Address decode
  // ============================================================
  always_comb begin
    case (wb_adr_i & REGION_MASK)
      RAM_BASE:   region = REGION_RAM;
      CLINT_BASE: region = REGION_CLINT;
      // Only the UART0 slot is populated on the peripheral bus
      PBUS_BASE:  region = (wb_adr_i[19:16] == UART0_SLOT) ? REGION_PBUS : REGION_NONE;
      default:    region = REGION_NONE;
    endcase
  end

  // One strobe at most
  assign ram_stb_o   = req && (region == REGION_RAM);
  assign clint_stb_o = req && (region == REGION_CLINT);
  assign uart_stb_o  = req && (region == REGION_PBUS);

  // Err pulse, low again on the cycle the master completes
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      err_q <= 1'b0;
    end else begin
      err_q <= req && (region == REGION_NONE) && !err_q;
    end
  end

  assign wb_err_o = err_q;

  // ============================================================
  // Response mux
  // ============================================================
  always_comb begin
    wb_dat_o = '0;
    wb_ack_o = 1'b0;
    case (region)
      REGION_RAM: begin
        wb_dat_o = ram_dat_i;
        wb_ack_o = ram_ack_i;
      end
      REGION_CLINT: begin
        wb_dat_o = clint_dat_i;
        wb_ack_o = clint_ack_i;
      end
      REGION_PBUS: begin
        wb_dat_o = uart_dat_i;
        wb_ack_o = uart_ack_i;
      end
      default: begin
        wb_dat_o = '0;
        wb_ack_o = 1'b0;
      end
    endcase
  end

  // Slaves never answer together
  a_one_slave_ack : assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0({ram_ack_i, clint_ack_i, uart_ack_i}));

  // A transfer ends with ack or err, not both
  a_ack_err_excl : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(wb_ack_o && wb_err_o));

endmodule

/* hdl/soc_pkg.sv */
/* Memory map, bus types and CTI codes for the single-master Wishbone fabric.
   Region decode uses the top address nibble only. */
package soc_pkg;

  // ============================================================
  // Bus widths
  // ============================================================
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  sel_t;

  // Decoded target of the current request
  typedef enum logic [1:0] {
    REGION_RAM,
    REGION_CLINT,
    REGION_PBUS,
    REGION_NONE
  } region_e;

  // Wishbone B4 cycle type identifier
  typedef enum logic [2:0] {
    CTI_CLASSIC = 3'b000,
    CTI_INCR    = 3'b010,
    CTI_EOB     = 3'b111
  } cti_e;

  // ============================================================
  // Memory map
  // ============================================================
  localparam addr_t RAM_BASE    = 32'h8000_0000;
  localparam addr_t CLINT_BASE  = 32'h3000_0000;
  localparam addr_t PBUS_BASE   = 32'h2000_0000;
  localparam addr_t REGION_MASK = 32'hF000_0000;

  // Peripheral slot, compared against address bits 19:16
  localparam logic [3:0] UART0_SLOT = 4'h0;

  // CLINT register offsets, low 16 address bits
  localparam logic [15:0] CLINT_MSIP_OFS     = 16'h0000;
  localparam logic [15:0] CLINT_MTIMECMP_OFS = 16'h4000;
  localparam logic [15:0] CLINT_MTIME_OFS    = 16'hBFF8;

  // UART register offsets, low 16 address bits
  localparam logic [15:0] UART_DATA_OFS   = 16'h0000;
  localparam logic [15:0] UART_STATUS_OFS = 16'h0004;

  // Words held by one RAM line buffer
  localparam int LINE_WORDS = 4;

endpackage
